// ==== Makefile ====
TOP = tb_ps2_keyboard
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/key_matrix.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_matrix (
	input logic clk,
	input logic rst,
	input logic event_valid,
	output logic event_ready,
	input keyboard_pkg::key_code_t event_code,
	input logic event_release,
	input logic event_clear,
	input keyboard_pkg::matrix_lines_t row_select,
	output keyboard_pkg::matrix_lines_t col_sense
);

	import keyboard_pkg::*;

	// Pressed keys, one active-high bit per column in each row
	matrix_lines_t key_down [MATRIX_ROWS];

	// Clear sweep
	logic clearing;
	matrix_row_t sweep_row;

	// Event intake
	logic take;
	key_pos_t pos;

	// OR of the selected rows
	matrix_lines_t cols_down;

	// No events accepted while rows are being swept
	assign event_ready = !clearing;
	assign take = event_valid && event_ready;
	assign pos = key_position(event_code);

	//////////////////////////////////////////////////
	// Clear sweep control
	//////////////////////////////////////////////////

	// One row per cycle, 0 up to the last row
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clearing <= 1'b0;
			sweep_row <= '0;
		end
		else if (clearing)
		begin
			sweep_row <= sweep_row + 1'b1;
			if (sweep_row == matrix_row_t'(MATRIX_ROWS - 1))
				clearing <= 1'b0;
		end
		else if (take && event_clear)
		begin
			clearing <= 1'b1;
			sweep_row <= '0;
		end
	end

	//////////////////////////////////////////////////
	// Key state
	//////////////////////////////////////////////////

	// Unmapped codes are taken off the handshake and dropped
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int r = 0; r < MATRIX_ROWS; r++)
				key_down[r] <= '0;
		end
		else if (clearing)
			key_down[sweep_row] <= '0;
		else if (take && !event_clear && pos.mapped)
			key_down[pos.row][pos.col] <= !event_release;
	end

	// Host read port
	// Several low row selects combine like shorted matrix lines
	always_comb
	begin
		cols_down = '0;
		for (int r = 0; r < MATRIX_ROWS; r++)
		begin
			if (!row_select[r])
				cols_down = cols_down | key_down[r];
		end
		col_sense = ~cols_down;
	end

	// Back-pressure never outlasts one sweep
	a_sweep_len: assert property (@(posedge clk) disable iff (rst)
		!event_ready [*MATRIX_ROWS] |=> event_ready);

endmodule

`default_nettype wire

// ==== hw/keyboard_pkg.sv ====
`default_nettype none

package keyboard_pkg;

	//////////////////////////////////////////////////
	// Host keyboard matrix
	//////////////////////////////////////////////////

	// 8x8 matrix, rows driven by the host, columns sensed
	localparam int MATRIX_ROWS = 8;

	typedef logic [2:0] matrix_row_t;
	typedef logic [2:0] matrix_col_t;
	// Active low, one bit per row or column
	typedef logic [MATRIX_ROWS-1:0] matrix_lines_t;
	// Extended flag in bit 8, scancode below
	typedef logic [8:0] key_code_t;

	// Prefix tracking in the decoder
	typedef enum logic [1:0] {IDLE, EXT, BREAK, EXT_BREAK} dec_state_t;

	// Result of a table lookup
	typedef struct packed {
		logic mapped;
		matrix_row_t row;
		matrix_col_t col;
	} key_pos_t;

	//////////////////////////////////////////////////
	// Scancode set 2 to matrix position
	//////////////////////////////////////////////////

	function automatic key_pos_t key_position(input key_code_t code);
		key_pos_t pos;
		// Anything not listed is ignored
		pos = '{mapped: 1'b0, row: '0, col: '0};
		case (code)
			// Row 0, editing and cursor keys
			9'h066: pos = '{1'b1, 3'd0, 3'd0};
			9'h05A: pos = '{1'b1, 3'd0, 3'd1};
			9'h174: pos = '{1'b1, 3'd0, 3'd2};
			9'h083: pos = '{1'b1, 3'd0, 3'd3};
			9'h172: pos = '{1'b1, 3'd0, 3'd4};
			9'h175: pos = '{1'b1, 3'd0, 3'd7};
			// Row 1
			9'h026: pos = '{1'b1, 3'd1, 3'd0};
			9'h01D: pos = '{1'b1, 3'd1, 3'd1};
			9'h01C: pos = '{1'b1, 3'd1, 3'd2};
			9'h025: pos = '{1'b1, 3'd1, 3'd3};
			9'h01A: pos = '{1'b1, 3'd1, 3'd4};
			9'h01B: pos = '{1'b1, 3'd1, 3'd5};
			9'h024: pos = '{1'b1, 3'd1, 3'd6};
			9'h012: pos = '{1'b1, 3'd1, 3'd7};
			// Row 2
			9'h02E: pos = '{1'b1, 3'd2, 3'd0};
			9'h02D: pos = '{1'b1, 3'd2, 3'd1};
			9'h023: pos = '{1'b1, 3'd2, 3'd2};
			9'h036: pos = '{1'b1, 3'd2, 3'd3};
			9'h021: pos = '{1'b1, 3'd2, 3'd4};
			9'h02B: pos = '{1'b1, 3'd2, 3'd5};
			9'h02C: pos = '{1'b1, 3'd2, 3'd6};
			9'h022: pos = '{1'b1, 3'd2, 3'd7};
			// Row 7, digits, space and Q
			9'h016: pos = '{1'b1, 3'd7, 3'd0};
			9'h01E: pos = '{1'b1, 3'd7, 3'd3};
			9'h029: pos = '{1'b1, 3'd7, 3'd4};
			9'h015: pos = '{1'b1, 3'd7, 3'd6};
			default: pos = '{1'b0, 3'd0, 3'd0};
		endcase
		return pos;
	endfunction

endpackage

`default_nettype wire

// ==== hw/ps2_keyboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	input keyboard_pkg::matrix_lines_t row_select,
	output keyboard_pkg::matrix_lines_t col_sense,
	output logic frame_error,
	output logic overrun
);

	import ps2_pkg::*;
	import keyboard_pkg::*;

	// Receiver to decoder strobe
	logic byte_valid;
	scancode_t byte_data;

	// Decoder to matrix handshake
	logic event_valid;
	logic event_ready;
	key_code_t event_code;
	logic event_release;
	logic event_clear;

	//////////////////////////////////////////////////
	// Receive, decode, hold
	//////////////////////////////////////////////////

	ps2_receiver u_ps2_receiver (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	scancode_decoder u_scancode_decoder (
		.clk           (clk),
		.rst           (rst),
		.byte_valid    (byte_valid),
		.byte_data     (byte_data),
		.event_valid   (event_valid),
		.event_ready   (event_ready),
		.event_code    (event_code),
		.event_release (event_release),
		.event_clear   (event_clear),
		.overrun       (overrun)
	);

	key_matrix u_key_matrix (
		.clk           (clk),
		.rst           (rst),
		.event_valid   (event_valid),
		.event_ready   (event_ready),
		.event_code    (event_code),
		.event_release (event_release),
		.event_clear   (event_clear),
		.row_select    (row_select),
		.col_sense     (col_sense)
	);

endmodule

`default_nettype wire

// ==== hw/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

	//////////////////////////////////////////////////
	// PS/2 line protocol
	//////////////////////////////////////////////////

	// Equal ps2_clk samples needed before the filtered level moves
	localparam int FILTER_LEN = 8;

	// Start bit, 8 data bits LSB first, odd parity, stop bit
	localparam int FRAME_BITS = 11;

	// Idle cycles after a falling edge before a partial frame is dropped
	// Roughly 100 us at a 28 MHz system clock
	localparam int WATCHDOG_CYCLES = 2900;

	//////////////////////////////////////////////////
	// Receiver widths
	//////////////////////////////////////////////////

	// One byte as sent by the keyboard
	typedef logic [7:0] scancode_t;
	// Whole frame as shifted in
	typedef logic [FRAME_BITS-1:0] frame_t;
	// Bits received so far, counts up to FRAME_BITS
	typedef logic [$clog2(FRAME_BITS+1)-1:0] bit_count_t;
	// Watchdog down counter
	typedef logic [$clog2(WATCHDOG_CYCLES+1)-1:0] watchdog_t;
	// Older clock samples, the newest sample completes FILTER_LEN
	typedef logic [FILTER_LEN-2:0] clk_history_t;

	// Special bytes from the keyboard
	localparam scancode_t SC_EXTENDED    = 8'hE0;
	localparam scancode_t SC_BREAK       = 8'hF0;
	localparam scancode_t SC_SELFTEST_OK = 8'hAA;

endpackage

`default_nettype wire

// ==== hw/ps2_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_receiver (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output logic byte_valid,
	output ps2_pkg::scancode_t byte_data,
	output logic frame_error
);

	import ps2_pkg::*;

	// Pin synchronizers with bit 1 as the usable sample
	logic [1:0] clk_sync;
	logic [1:0] data_sync;

	// Glitch filter on the keyboard clock
	clk_history_t clk_hist;
	logic clk_level;
	logic clk_level_d;
	logic fall;

	// Frame assembly
	frame_t shift;
	bit_count_t bit_cnt;
	watchdog_t watchdog;
	logic frame_done;
	logic frame_ok;

	//////////////////////////////////////////////////
	// Synchronizer and clock filter
	//////////////////////////////////////////////////

	// Both lines idle high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	// Level moves only after FILTER_LEN equal samples
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clk_hist <= '1;
			clk_level <= 1'b1;
			clk_level_d <= 1'b1;
		end
		else
		begin
			clk_hist <= {clk_hist[FILTER_LEN-3:0], clk_sync[1]};
			if (&{clk_hist, clk_sync[1]})
				clk_level <= 1'b1;
			else if (~|{clk_hist, clk_sync[1]})
				clk_level <= 1'b0;
			// Previous level for edge detection
			clk_level_d <= clk_level;
		end
	end

	assign fall = clk_level_d & ~clk_level;

	//////////////////////////////////////////////////
	// Frame shifter, bit counter and watchdog
	//////////////////////////////////////////////////

	// LSB first, so the start bit ends up in bit 0
	always_ff @(posedge clk)
	begin
		if (fall)
			shift <= {data_sync[1], shift[FRAME_BITS-1:1]};
	end

	assign frame_done = (bit_cnt == bit_count_t'(FRAME_BITS));
	// Start low, odd parity over data and parity, stop high
	assign frame_ok = ~shift[0] & (^shift[FRAME_BITS-2:1]) & shift[FRAME_BITS-1];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bit_cnt <= '0;
			watchdog <= '0;
			byte_valid <= 1'b0;
			frame_error <= 1'b0;
		end
		else
		begin
			// Both strobes last one cycle
			byte_valid <= frame_done & frame_ok;
			frame_error <= frame_done & ~frame_ok;
			// Reload on every edge, count down while the line is quiet
			if (fall)
				watchdog <= watchdog_t'(WATCHDOG_CYCLES);
			else if (watchdog != '0)
				watchdog <= watchdog - 1'b1;
			if (frame_done)
				bit_cnt <= '0;
			else if (fall)
				bit_cnt <= bit_cnt + 1'b1;
			else if (watchdog == '0)
				bit_cnt <= '0; // Stalled frame thrown away
		end
	end

	// Data byte sits between start and parity
	always_ff @(posedge clk)
	begin
		if (frame_done)
			byte_data <= shift[8:1];
	end

	// Each completed frame gives one outcome that lasts a single cycle
	a_one_outcome: assert property (@(posedge clk) disable iff (rst)
		byte_valid || frame_error |=> !byte_valid && !frame_error);

endmodule

`default_nettype wire

// ==== hw/scancode_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module scancode_decoder (
	input logic clk,
	input logic rst,
	input logic byte_valid,
	input ps2_pkg::scancode_t byte_data,
	output logic event_valid,
	input logic event_ready,
	output keyboard_pkg::key_code_t event_code,
	output logic event_release,
	output logic event_clear,
	output logic overrun
);

	import ps2_pkg::*;
	import keyboard_pkg::*;

	dec_state_t state;

	// Prefixes seen so far
	logic ext_seen;
	logic break_seen;

	// Byte handling
	logic pending;
	logic accept;
	logic is_prefix;
	logic new_event;

	assign ext_seen = (state == EXT) || (state == EXT_BREAK);
	assign break_seen = (state == BREAK) || (state == EXT_BREAK);

	// Event still waiting on the matrix
	assign pending = event_valid && !event_ready;
	// Bytes arriving during back-pressure are lost
	assign accept = byte_valid && !pending;
	assign is_prefix = (byte_data == SC_EXTENDED) || (byte_data == SC_BREAK);
	assign new_event = accept && !is_prefix;

	//////////////////////////////////////////////////
	// Prefix state machine
	//////////////////////////////////////////////////

	// E0 and F0 may come in either order, any key byte ends the sequence
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else if (accept)
		begin
			if (byte_data == SC_EXTENDED)
				state <= break_seen ? EXT_BREAK : EXT;
			else if (byte_data == SC_BREAK)
				state <= ext_seen ? EXT_BREAK : BREAK;
			else
				state <= IDLE;
		end
	end

	//////////////////////////////////////////////////
	// Event handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			event_valid <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			overrun <= byte_valid && pending;
			// A new event may replace one taken in the same cycle
			if (new_event)
				event_valid <= 1'b1;
			else if (event_ready)
				event_valid <= 1'b0;
		end
	end

	// Payload loads only with a new event, so it holds under back-pressure
	always_ff @(posedge clk)
	begin
		if (new_event)
		begin
			event_code <= {ext_seen, byte_data};
			event_release <= break_seen;
			// AA after a prefix is a plain key byte
			event_clear <= (state == IDLE) && (byte_data == SC_SELFTEST_OK);
		end
	end

	// Event stays offered and unchanged until the matrix takes it
	a_payload_hold: assert property (@(posedge clk) disable iff (rst)
		event_valid && !event_ready |=>
			event_valid && $stable({event_code, event_release, event_clear}));

endmodule

`default_nettype wire

// ==== src.f ====
hw/ps2_pkg.sv
hw/keyboard_pkg.sv
hw/ps2_receiver.sv
hw/scancode_decoder.sv
hw/key_matrix.sv
hw/ps2_keyboard.sv
tests/tb_ps2_keyboard.sv

// ==== tests/tb_ps2_keyboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ps2_keyboard;

	import keyboard_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int SETTLE_CYCLES = 3000;
	// Longer than the receiver watchdog
	localparam int STALL_CYCLES = 3500;

	logic clk;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	matrix_lines_t row_select;
	matrix_lines_t col_sense;
	logic frame_error;
	logic overrun;

	// Pulse counters and results
	int frame_errors = 0;
	int overruns = 0;
	int checks = 0;
	int errors = 0;

	// Stimulus table, one index per entry
	string names[$];
	logic [31:0] seqs[$];
	int lens[$];
	bit bad_flags[$];
	int stall_bits[$];
	matrix_lines_t row_sels[$];
	matrix_lines_t exp_cols[$];
	int exp_errs[$];

	ps2_keyboard u_ps2_keyboard (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.row_select  (row_select),
		.col_sense   (col_sense),
		.frame_error (frame_error),
		.overrun     (overrun)
	);

	// 4 ns system clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Strobes counted on every edge out of reset
	always @(posedge clk)
	begin
		if (!rst && frame_error)
			frame_errors = frame_errors + 1;
		if (!rst && overrun)
			overruns = overruns + 1;
	end

	//////////////////////////////////////////////////
	// PS/2 line driver
	//////////////////////////////////////////////////

	// Wait n edges, then step 1 ns past the last one
	task automatic tick(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
		#1;
	endtask

	// Jittered keyboard half period, 20 to 40 cycles
	function automatic int half_period();
		return 20 + int'($urandom % 21);
	endfunction

	// Data changes while the keyboard clock is high
	task automatic send_bit(input logic value);
		ps2_data = value;
		tick(half_period());
		ps2_clk = 1'b0;
		tick(half_period());
		ps2_clk = 1'b1;
	endtask

	// Start, data LSB first, odd parity, stop
	task automatic send_byte(input logic [7:0] value, input bit bad_parity);
		logic parity;
		parity = ~^value;
		if (bad_parity)
			parity = ~parity;
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(value[i]);
		send_bit(parity);
		send_bit(1'b1);
		ps2_data = 1'b1;
		tick(half_period());
	endtask

	// Start bit and a few zero data bits, then the line goes quiet
	task automatic send_partial(input int bits);
		for (int i = 0; i < bits; i++)
			send_bit(1'b0);
		ps2_data = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic check_cols(input string name, input matrix_lines_t expected,
			input matrix_lines_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected col_sense %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("ERROR %s: expected %0d pulses, actual %0d", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Table
	//////////////////////////////////////////////////

	// First byte sits in the highest used byte of seq
	task automatic add_entry(input string name, input logic [31:0] seq, input int len,
			input bit bad, input int stall, input matrix_lines_t rsel,
			input matrix_lines_t cols, input int errs);
		names.push_back(name);
		seqs.push_back(seq);
		lens.push_back(len);
		bad_flags.push_back(bad);
		stall_bits.push_back(stall);
		row_sels.push_back(rsel);
		exp_cols.push_back(cols);
		exp_errs.push_back(errs);
	endtask

	// Matrix state carries over from one entry to the next
	task automatic load_table();
		add_entry("a_make", 32'h1C, 1, 1'b0, 0, ~8'h02, ~8'h04, 0);
		add_entry("a_break", 32'hF01C, 2, 1'b0, 0, ~8'h02, 8'hFF, 0);
		add_entry("shift_a_make", 32'h121C, 2, 1'b0, 0, ~8'h02, ~8'h84, 0);
		add_entry("shift_a_break", 32'hF012F01C, 4, 1'b0, 0, ~8'h02, 8'hFF, 0);
		add_entry("up_make", 32'hE075, 2, 1'b0, 0, ~8'h01, ~8'h80, 0);
		add_entry("up_break", 32'hE0F075, 3, 1'b0, 0, ~8'h01, 8'hFF, 0);
		add_entry("down_make", 32'hE072, 2, 1'b0, 0, ~8'h01, ~8'h10, 0);
		// Plain 72 is unmapped, down-arrow stays pressed
		add_entry("down_plain_break", 32'hF072, 2, 1'b0, 0, ~8'h01, ~8'h10, 0);
		add_entry("down_ext_break", 32'hE0F072, 3, 1'b0, 0, ~8'h01, 8'hFF, 0);
		// Rows 0 and 7 read together
		add_entry("space_return", 32'h295A, 2, 1'b0, 0, 8'h7E, ~8'h12, 0);
		add_entry("bad_parity", 32'h16, 1, 1'b1, 0, 8'h7E, ~8'h12, 1);
		add_entry("watchdog", 32'h16, 1, 1'b0, 5, ~8'h80, ~8'h11, 0);
		add_entry("keys_held", 32'h1C, 1, 1'b0, 0, 8'h00, ~8'h17, 0);
		add_entry("selftest_clear", 32'hAA, 1, 1'b0, 0, 8'h00, 8'hFF, 0);
		add_entry("key_after_clear", 32'h1E, 1, 1'b0, 0, ~8'h80, ~8'h08, 0);
	endtask

	task automatic run_entry(input int idx);
		int errs_before;
		logic [31:0] seq;
		errs_before = frame_errors;
		seq = seqs[idx];
		row_select = row_sels[idx];
		if (stall_bits[idx] > 0)
		begin
			send_partial(stall_bits[idx]);
			tick(STALL_CYCLES);
		end
		for (int b = lens[idx] - 1; b >= 0; b--)
			send_byte(seq[b*8 +: 8], bad_flags[idx]);
		tick(SETTLE_CYCLES);
		check_cols(names[idx], exp_cols[idx], col_sense);
		check_count(names[idx], exp_errs[idx], frame_errors - errs_before);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hd613));
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		row_select = '1;
		tick(RESET_CYCLES);
		rst = 1'b0;
		// Every row selected, nothing pressed
		row_select = '0;
		tick(1);
		check_cols("reset", 8'hFF, col_sense);
		load_table();
		for (int i = 0; i < names.size(); i++)
			run_entry(i);
		check_count("overrun", 0, overruns);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
